// File: compile.f
+incdir+testbench
hdl/core_pkg.sv
hdl/register_file.sv
hdl/forwarding_unit.sv
hdl/operand_pipe.sv
hdl/exec_unit.sv
hdl/pipeline_control.sv
hdl/operand_core_top.sv
testbench/tb_operand_core.sv

// File: hdl/core_pkg.sv
package core_pkg;

    // data path widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 16;
    localparam int OP_W       = 3;

    typedef logic [XLEN-1:0]       xlen_t;      // register value
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // register index
    typedef logic [IMM_W-1:0]      imm_t;       // sign-extended in exec
    typedef logic [OP_W-1:0]       op_t;
    typedef logic [2:0]            src_fp_t;    // [2] rs1, [1] rs2, [0] rs3

    // opcodes
    localparam op_t OP_ADD     = 3'd0;  // int rd = rs1 + rs2
    localparam op_t OP_ADDI    = 3'd1;  // int rd = rs1 + sext(imm)
    localparam op_t OP_XOR     = 3'd2;  // int rd = rs1 ^ rs2
    localparam op_t OP_FSGNJ   = 3'd3;  // fp rd = |rs1| with sign of rs2
    localparam op_t OP_FSGNJX  = 3'd4;  // fp rd = |rs1| with sign1 ^ sign2
    localparam op_t OP_FSEL3   = 3'd5;  // fp rd = rs3 ? rs1 : rs2, bitwise
    localparam op_t OP_FMV_X_W = 3'd6;  // int rd = fp rs1
    localparam op_t OP_FMV_W_X = 3'd7;  // fp rd = int rs1

    // bit position of each source inside src_fp_t
    localparam int SRC_RS1 = 2;
    localparam int SRC_RS2 = 1;
    localparam int SRC_RS3 = 0;

    // source classes used by the decoder
    localparam src_fp_t SRC_INT     = 3'b000;  // all sources integer
    localparam src_fp_t SRC_FP_RS1  = 3'b100;  // only rs1 from fp file
    localparam src_fp_t SRC_FP_RS12 = 3'b110;  // sign injection
    localparam src_fp_t SRC_FP_ALL  = 3'b111;  // three-source select

endpackage

// File: hdl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  op_t   op_e,
    input  xlen_t opa_e,
    input  xlen_t opb_e,
    input  xlen_t opc_e,
    input  imm_t  imm_e,
    output xlen_t result_w
);

    xlen_t imm_ext;
    xlen_t result_e;

    assign imm_ext = {{(XLEN-IMM_W){imm_e[IMM_W-1]}}, imm_e};

    always_comb begin
        case (op_e)
            OP_ADD:     result_e = opa_e + opb_e;
            OP_ADDI:    result_e = opa_e + imm_ext;
            OP_XOR:     result_e = opa_e ^ opb_e;
            // sign injection keeps the magnitude of rs1
            OP_FSGNJ:   result_e = {opb_e[XLEN-1], opa_e[XLEN-2:0]};
            OP_FSGNJX:  result_e = {opa_e[XLEN-1] ^ opb_e[XLEN-1], opa_e[XLEN-2:0]};
            OP_FSEL3:   result_e = (opa_e & opc_e) | (opb_e & ~opc_e);  // rs3 is the mask
            OP_FMV_X_W: result_e = opa_e;   // raw bit move, fp to int
            OP_FMV_W_X: result_e = opa_e;   // int to fp
            default:    result_e = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_w <= '0;
        end else begin
            result_w <= result_e;
        end
    end

endmodule

// File: hdl/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit
    import core_pkg::*;
(
    // from DP stage
    input  reg_addr_t rs1_dp,
    input  reg_addr_t rs2_dp,
    input  reg_addr_t rs3_dp,
    input  src_fp_t   rs_fpu_dp,

    // to DP stage
    output logic      forward_rd1_dp,
    output logic      forward_rd2_dp,
    output logic      forward_fpu_rd1_dp,
    output logic      forward_fpu_rd2_dp,
    output logic      forward_fpu_rd3_dp,

    // from E stage
    input  reg_addr_t rs1_e,
    input  reg_addr_t rs2_e,
    input  reg_addr_t rs3_e,
    input  src_fp_t   rs_fpu_e,

    // to E stage
    output logic      forward_rd1_e,
    output logic      forward_rd2_e,
    output logic      forward_fpu_rd1_e,
    output logic      forward_fpu_rd2_e,
    output logic      forward_fpu_rd3_e,

    // from W stage
    input  reg_addr_t rd_w,
    input  logic      reg_write_w,
    input  logic      fpu_reg_write_w
);

    // integer sources never take a forward on x0
    assign forward_rd1_dp = (rs1_dp == rd_w) && !rs_fpu_dp[SRC_RS1] && reg_write_w
                            && (rs1_dp != '0);
    assign forward_rd2_dp = (rs2_dp == rd_w) && !rs_fpu_dp[SRC_RS2] && reg_write_w
                            && (rs2_dp != '0);

    // fp sources, f0 is an ordinary register
    assign forward_fpu_rd1_dp = (rs1_dp == rd_w) && rs_fpu_dp[SRC_RS1] && fpu_reg_write_w;
    assign forward_fpu_rd2_dp = (rs2_dp == rd_w) && rs_fpu_dp[SRC_RS2] && fpu_reg_write_w;
    assign forward_fpu_rd3_dp = (rs3_dp == rd_w) && rs_fpu_dp[SRC_RS3] && fpu_reg_write_w;

    // same rules one stage later
    assign forward_rd1_e = (rs1_e == rd_w) && !rs_fpu_e[SRC_RS1] && reg_write_w
                           && (rs1_e != '0);
    assign forward_rd2_e = (rs2_e == rd_w) && !rs_fpu_e[SRC_RS2] && reg_write_w
                           && (rs2_e != '0);

    assign forward_fpu_rd1_e = (rs1_e == rd_w) && rs_fpu_e[SRC_RS1] && fpu_reg_write_w;
    assign forward_fpu_rd2_e = (rs2_e == rd_w) && rs_fpu_e[SRC_RS2] && fpu_reg_write_w;
    assign forward_fpu_rd3_e = (rs3_e == rd_w) && rs_fpu_e[SRC_RS3] && fpu_reg_write_w;

endmodule

// File: hdl/operand_core_top.sv
`timescale 1ns/1ps

module operand_core_top
    import core_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      in_valid,
    input  op_t       in_op,
    input  reg_addr_t in_rs1,
    input  reg_addr_t in_rs2,
    input  reg_addr_t in_rs3,
    input  reg_addr_t in_rd,
    input  imm_t      in_imm,

    output logic      result_valid,
    output reg_addr_t result_rd,
    output logic      result_fp,
    output xlen_t     result_data
);

    reg_addr_t rs1_dp, rs2_dp, rs3_dp, rs1_e, rs2_e, rs3_e, rd_w;
    src_fp_t   rs_fpu_dp, rs_fpu_e;
    imm_t      imm_dp, imm_e;
    op_t       op_e;
    logic      reg_write_w, fpu_reg_write_w, valid_w;
    logic      fwd_rd1_dp, fwd_rd2_dp, fwd_fpu_rd1_dp, fwd_fpu_rd2_dp, fwd_fpu_rd3_dp;
    logic      fwd_rd1_e, fwd_rd2_e, fwd_fpu_rd1_e, fwd_fpu_rd2_e, fwd_fpu_rd3_e;
    xlen_t     opa_e, opb_e, opc_e, result_w;
    reg_addr_t int_raddr [2];
    reg_addr_t fp_raddr [3];
    xlen_t     int_rdata [2];
    xlen_t     fp_rdata [3];

    // both files are addressed from DP
    assign int_raddr[0] = rs1_dp;
    assign int_raddr[1] = rs2_dp;
    assign fp_raddr[0]  = rs1_dp;
    assign fp_raddr[1]  = rs2_dp;
    assign fp_raddr[2]  = rs3_dp;

    pipeline_control u_ctrl (
        .clk, .rst_n, .in_valid, .in_op, .in_rs1, .in_rs2, .in_rs3, .in_rd, .in_imm,
        .rs1_dp, .rs2_dp, .rs3_dp, .rs_fpu_dp, .imm_dp,
        .rs1_e, .rs2_e, .rs3_e, .rs_fpu_e, .op_e,
        .rd_w, .reg_write_w, .fpu_reg_write_w, .valid_w
    );

    register_file #(.NUM_REGS(NUM_REGS), .NUM_READ(2), .ZERO_REG(1'b1)) int_rf (
        .clk, .rst_n, .we(reg_write_w), .waddr(rd_w), .wdata(result_w),
        .raddr(int_raddr), .rdata(int_rdata)
    );

    register_file #(.NUM_REGS(NUM_REGS), .NUM_READ(3), .ZERO_REG(1'b0)) fp_rf (
        .clk, .rst_n, .we(fpu_reg_write_w), .waddr(rd_w), .wdata(result_w),
        .raddr(fp_raddr), .rdata(fp_rdata)
    );

    forwarding_unit u_fwd (
        .rs1_dp, .rs2_dp, .rs3_dp, .rs_fpu_dp,
        .forward_rd1_dp(fwd_rd1_dp), .forward_rd2_dp(fwd_rd2_dp),
        .forward_fpu_rd1_dp(fwd_fpu_rd1_dp), .forward_fpu_rd2_dp(fwd_fpu_rd2_dp),
        .forward_fpu_rd3_dp(fwd_fpu_rd3_dp),
        .rs1_e, .rs2_e, .rs3_e, .rs_fpu_e,
        .forward_rd1_e(fwd_rd1_e), .forward_rd2_e(fwd_rd2_e),
        .forward_fpu_rd1_e(fwd_fpu_rd1_e), .forward_fpu_rd2_e(fwd_fpu_rd2_e),
        .forward_fpu_rd3_e(fwd_fpu_rd3_e),
        .rd_w, .reg_write_w, .fpu_reg_write_w
    );

    operand_pipe u_opnd (
        .clk, .rst_n, .rf_int_rdata(int_rdata), .rf_fp_rdata(fp_rdata), .rs_fpu_dp,
        .forward_rd1_dp(fwd_rd1_dp), .forward_rd2_dp(fwd_rd2_dp),
        .forward_fpu_rd1_dp(fwd_fpu_rd1_dp), .forward_fpu_rd2_dp(fwd_fpu_rd2_dp),
        .forward_fpu_rd3_dp(fwd_fpu_rd3_dp),
        .forward_rd1_e(fwd_rd1_e), .forward_rd2_e(fwd_rd2_e),
        .forward_fpu_rd1_e(fwd_fpu_rd1_e), .forward_fpu_rd2_e(fwd_fpu_rd2_e),
        .forward_fpu_rd3_e(fwd_fpu_rd3_e),
        .imm_dp, .result_w, .opa_e, .opb_e, .opc_e, .imm_e
    );

    exec_unit u_exec (
        .clk, .rst_n, .op_e, .opa_e, .opb_e, .opc_e, .imm_e, .result_w
    );

    assign result_valid = valid_w;
    assign result_rd    = rd_w;
    assign result_fp    = fpu_reg_write_w;
    assign result_data  = result_w;

endmodule

// File: hdl/operand_pipe.sv
`timescale 1ns/1ps

module operand_pipe
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    // register file read data for the DP sources
    input  xlen_t   rf_int_rdata [2],
    input  xlen_t   rf_fp_rdata [3],
    input  src_fp_t rs_fpu_dp,

    // DP forward selects
    input  logic    forward_rd1_dp,
    input  logic    forward_rd2_dp,
    input  logic    forward_fpu_rd1_dp,
    input  logic    forward_fpu_rd2_dp,
    input  logic    forward_fpu_rd3_dp,

    // E forward selects
    input  logic    forward_rd1_e,
    input  logic    forward_rd2_e,
    input  logic    forward_fpu_rd1_e,
    input  logic    forward_fpu_rd2_e,
    input  logic    forward_fpu_rd3_e,

    input  imm_t    imm_dp,
    input  xlen_t   result_w,     // W result, the forward source

    output xlen_t   opa_e,
    output xlen_t   opb_e,
    output xlen_t   opc_e,
    output imm_t    imm_e
);

    xlen_t opa_dp, opb_dp, opc_dp;   // DP operands after forwarding
    xlen_t opa_q, opb_q, opc_q;      // E operand registers

    // pick the file by source class, then the DP forward
    always_comb begin
        opa_dp = rs_fpu_dp[SRC_RS1] ? rf_fp_rdata[0] : rf_int_rdata[0];
        opb_dp = rs_fpu_dp[SRC_RS2] ? rf_fp_rdata[1] : rf_int_rdata[1];
        opc_dp = rf_fp_rdata[2];      // rs3 exists only in the fp file
        if (forward_rd1_dp || forward_fpu_rd1_dp) opa_dp = result_w;
        if (forward_rd2_dp || forward_fpu_rd2_dp) opb_dp = result_w;
        if (forward_fpu_rd3_dp) opc_dp = result_w;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opa_q <= '0;
            opb_q <= '0;
            opc_q <= '0;
            imm_e <= '0;
        end else begin
            opa_q <= opa_dp;
            opb_q <= opb_dp;
            opc_q <= opc_dp;
            imm_e <= imm_dp;
        end
    end

    // the instruction now in W was in E while these were read
    assign opa_e = (forward_rd1_e || forward_fpu_rd1_e) ? result_w : opa_q;
    assign opb_e = (forward_rd2_e || forward_fpu_rd2_e) ? result_w : opb_q;
    assign opc_e = forward_fpu_rd3_e ? result_w : opc_q;

endmodule

// File: hdl/pipeline_control.sv
`timescale 1ns/1ps

module pipeline_control
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // instruction strobe
    input  logic      in_valid,
    input  op_t       in_op,
    input  reg_addr_t in_rs1,
    input  reg_addr_t in_rs2,
    input  reg_addr_t in_rs3,
    input  reg_addr_t in_rd,
    input  imm_t      in_imm,

    // DP stage
    output reg_addr_t rs1_dp,
    output reg_addr_t rs2_dp,
    output reg_addr_t rs3_dp,
    output src_fp_t   rs_fpu_dp,
    output imm_t      imm_dp,

    // E stage
    output reg_addr_t rs1_e,
    output reg_addr_t rs2_e,
    output reg_addr_t rs3_e,
    output src_fp_t   rs_fpu_e,
    output op_t       op_e,

    // W stage
    output reg_addr_t rd_w,
    output logic      reg_write_w,
    output logic      fpu_reg_write_w,
    output logic      valid_w
);

    logic      valid_dp, valid_e;
    op_t       op_dp;
    reg_addr_t rd_dp, rd_e;
    logic      dst_int_w;  // destination classes in W
    logic      dst_fp_w;

    function automatic src_fp_t src_class(op_t op);
        case (op)
            OP_FSGNJ, OP_FSGNJX: return SRC_FP_RS12;
            OP_FSEL3:            return SRC_FP_ALL;
            OP_FMV_X_W:          return SRC_FP_RS1;
            default:             return SRC_INT;
        endcase
    endfunction

    function automatic logic dst_is_int(op_t op);
        return (op == OP_ADD) || (op == OP_ADDI) || (op == OP_XOR)
               || (op == OP_FMV_X_W);
    endfunction

    function automatic logic dst_is_fp(op_t op);
        return (op == OP_FSGNJ) || (op == OP_FSGNJX) || (op == OP_FSEL3)
               || (op == OP_FMV_W_X);
    endfunction

    assign rs_fpu_dp = src_class(op_dp);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_dp  <= 1'b0;
            valid_e   <= 1'b0;
            valid_w   <= 1'b0;
            op_dp     <= OP_ADD;
            rs1_dp    <= '0;
            rs2_dp    <= '0;
            rs3_dp    <= '0;
            rd_dp     <= '0;
            imm_dp    <= '0;
            rs1_e     <= '0;
            rs2_e     <= '0;
            rs3_e     <= '0;
            rd_e      <= '0;
            rs_fpu_e  <= SRC_INT;
            op_e      <= OP_ADD;
            rd_w      <= '0;
            dst_int_w <= 1'b0;
            dst_fp_w  <= 1'b0;
        end else begin
            valid_dp <= in_valid;
            valid_e  <= valid_dp;
            valid_w  <= valid_e;
            if (in_valid) begin   // DP holds its fields through a gap
                op_dp  <= in_op;
                rs1_dp <= in_rs1;
                rs2_dp <= in_rs2;
                rs3_dp <= in_rs3;
                rd_dp  <= in_rd;
                imm_dp <= in_imm;
            end
            rs1_e     <= rs1_dp;
            rs2_e     <= rs2_dp;
            rs3_e     <= rs3_dp;
            rd_e      <= rd_dp;
            rs_fpu_e  <= rs_fpu_dp;
            op_e      <= op_dp;
            rd_w      <= rd_e;
            dst_int_w <= dst_is_int(op_e);
            dst_fp_w  <= dst_is_fp(op_e);
        end
    end

    // only a live W instruction may write
    assign reg_write_w     = valid_w && dst_int_w;
    assign fpu_reg_write_w = valid_w && dst_fp_w;

    a_one_file: assert property (@(posedge clk) disable iff (!rst_n)
        !(reg_write_w && fpu_reg_write_w));

    // strobe to W is exactly three edges, in both directions
    a_valid_lat: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> ##3 valid_w);
    a_valid_src: assert property (@(posedge clk) disable iff (!rst_n)
        valid_w |-> $past(in_valid, 3));

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ps

module register_file
    import core_pkg::*;
#(
    parameter int NUM_REGS = 32,
    parameter int NUM_READ = 2,
    parameter bit ZERO_REG = 1'b1    // x0 hard-wired to zero
) (
    input  logic      clk,
    input  logic      rst_n,

    // write port, driven from W
    input  logic      we,
    input  reg_addr_t waddr,
    input  xlen_t     wdata,

    // combinational read ports, addressed from DP
    input  reg_addr_t raddr [NUM_READ],
    output xlen_t     rdata [NUM_READ]
);

    xlen_t regs [NUM_REGS];
    logic  wr_blocked;   // write to the hard-wired zero register

    assign wr_blocked = ZERO_REG && (waddr == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (we && !wr_blocked) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_READ; i++) begin
            if (ZERO_REG && (raddr[i] == '0)) begin
                rdata[i] = '0;
            end else begin
                rdata[i] = regs[raddr[i]];
            end
        end
    end

    // a write must hit a defined register
    a_waddr_known: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> !$isunknown(waddr));

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the operand core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_operand_core \
    -Mdir obj_dir -o tb_operand_core

./obj_dir/tb_operand_core | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

// File: testbench/core_model.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// golden register files, updated in issue order
xlen_t gold_int [32];
xlen_t gold_fp [32];

function automatic void model_clear();
    for (int r = 0; r < 32; r++) begin
        gold_int[r] = '0;
        gold_fp[r]  = '0;
    end
endfunction

// x0 always reads zero, f0 is a normal register
function automatic xlen_t int_src(reg_addr_t a);
    return (a == 5'd0) ? '0 : gold_int[a];
endfunction

function automatic logic writes_fp(op_t op);
    case (op)
        OP_FSGNJ, OP_FSGNJX, OP_FSEL3, OP_FMV_W_X: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic xlen_t sext_imm(imm_t imm);
    xlen_t v;
    v = xlen_t'(imm);
    if (imm[15]) v = v | 32'hffff_0000;   // negative immediate
    return v;
endfunction

// expected result of one instruction, then its write into the golden files
function automatic xlen_t model_step(op_t op, reg_addr_t rs1, reg_addr_t rs2,
                                     reg_addr_t rs3, reg_addr_t rd, imm_t imm);
    xlen_t a_int;
    xlen_t b_int;
    xlen_t a_fp;
    xlen_t b_fp;
    xlen_t c_fp;
    xlen_t res;
    a_int = int_src(rs1);
    b_int = int_src(rs2);
    a_fp  = gold_fp[rs1];
    b_fp  = gold_fp[rs2];
    c_fp  = gold_fp[rs3];
    case (op)
        OP_ADD:     res = a_int + b_int;
        OP_ADDI:    res = a_int + sext_imm(imm);
        OP_XOR:     res = a_int ^ b_int;
        OP_FSGNJ:   res = (a_fp & 32'h7fff_ffff) | (b_fp & 32'h8000_0000);
        OP_FSGNJX:  res = (a_fp & 32'h7fff_ffff) | ((a_fp ^ b_fp) & 32'h8000_0000);
        OP_FSEL3: begin
            for (int i = 0; i < 32; i++) begin
                res[i] = c_fp[i] ? a_fp[i] : b_fp[i];   // mask bit picks rs1
            end
        end
        OP_FMV_X_W: res = a_fp;
        default:    res = a_int;   // int to fp move
    endcase
    if (writes_fp(op)) begin
        gold_fp[rd] = res;
    end else if (rd != 5'd0) begin
        gold_int[rd] = res;
    end
    return res;
endfunction

`endif

// File: testbench/tb_operand_core.sv
`timescale 1ns/1ps

module tb_operand_core
    import core_pkg::*;
();

    localparam int DRAIN_LIMIT = 50;   // cycles to wait for the last results

    logic      clk = 1'b0;
    logic      rst_n;
    logic      in_valid;
    op_t       in_op;
    reg_addr_t in_rs1, in_rs2, in_rs3, in_rd;
    imm_t      in_imm;
    logic      result_valid;
    reg_addr_t result_rd;
    logic      result_fp;
    xlen_t     result_data;

    int        cycle_cnt;
    xlen_t     exp_data_q [$];
    reg_addr_t exp_rd_q [$];
    logic      exp_fp_q [$];
    int        exp_cyc_q [$];   // cycle in which result_valid is due

    `include "core_model.svh"

    operand_core_top dut (
        .clk, .rst_n, .in_valid, .in_op, .in_rs1, .in_rs2, .in_rs3, .in_rd, .in_imm,
        .result_valid, .result_rd, .result_fp, .result_data
    );

    always #20 clk = ~clk;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_data(xlen_t got, xlen_t exp);
        if (got !== exp) begin
            $display("ERROR: %0t: result_data is %h, expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_rd(reg_addr_t got, reg_addr_t exp);
        if (got !== exp) begin
            $display("ERROR: %0t: result_rd is %0d, expected %0d", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_class(logic got, logic exp);
        if (got !== exp) begin
            $display("ERROR: %0t: result_fp is %b, expected %b", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_latency(int got, int exp);
        if (got != exp) begin
            $display("ERROR: %0t: result in cycle %0d, expected cycle %0d", $time, got, exp);
            abort_run();
        end
    endtask

    // outputs are registered, so mid-cycle sampling is stable
    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            if (exp_data_q.size() == 0) begin
                $display("result_valid was high at %0t with no instruction outstanding",
                         $time);
                abort_run();
            end else begin
                check_latency(cycle_cnt, exp_cyc_q.pop_front());
                check_rd(result_rd, exp_rd_q.pop_front());
                check_class(result_fp, exp_fp_q.pop_front());
                check_data(result_data, exp_data_q.pop_front());
            end
        end
    end

    // strobe one instruction 2 ns after a rising edge
    task automatic issue(op_t op, reg_addr_t rs1, reg_addr_t rs2, reg_addr_t rs3,
                         reg_addr_t rd, imm_t imm);
        in_valid = 1'b1;
        in_op    = op;
        in_rs1   = rs1;
        in_rs2   = rs2;
        in_rs3   = rs3;
        in_rd    = rd;
        in_imm   = imm;
        exp_data_q.push_back(model_step(op, rs1, rs2, rs3, rd, imm));
        exp_rd_q.push_back(rd);
        exp_fp_q.push_back(writes_fp(op));
        exp_cyc_q.push_back(cycle_cnt + 3);
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // mostly a pool of four so dependences are frequent
    function automatic reg_addr_t pick_reg();
        if ($urandom_range(0, 9) < 8) begin
            return reg_addr_t'($urandom_range(0, 3));
        end
        return reg_addr_t'($urandom_range(0, 31));
    endfunction

    task automatic random_run(int count, int gap_pct);
        for (int i = 0; i < count; i++) begin
            issue(op_t'($urandom_range(0, 7)), pick_reg(), pick_reg(), pick_reg(),
                  pick_reg(), imm_t'($urandom()));
            if ($urandom_range(0, 99) < gap_pct) begin
                idle(int'($urandom_range(1, 3)));
            end
        end
    endtask

    initial begin
        int waited;
        waited   = 0;
        $timeformat(-9, 0, " ns", 0);
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_op    = OP_ADD;
        in_rs1   = '0;
        in_rs2   = '0;
        in_rs3   = '0;
        in_rd    = '0;
        in_imm   = '0;
        void'($urandom(32'h801));
        model_clear();
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        idle(1);

        // all registers read zero after reset
        issue(OP_ADD, 5'd1, 5'd2, 5'd0, 5'd3, 16'h0);
        issue(OP_ADD, 5'd5, 5'd31, 5'd0, 5'd4, 16'h0);
        issue(OP_ADD, 5'd3, 5'd4, 5'd0, 5'd5, 16'h0);
        idle(2);

        // dependent chain at distance 1, 2 and 3
        issue(OP_ADDI, 5'd0, 5'd0, 5'd0, 5'd1, 16'd100);
        issue(OP_ADDI, 5'd1, 5'd0, 5'd0, 5'd2, 16'hfff6);
        issue(OP_ADD, 5'd1, 5'd2, 5'd0, 5'd3, 16'h0);
        issue(OP_ADD, 5'd1, 5'd3, 5'd0, 5'd4, 16'h0);
        idle(1);
        issue(OP_ADD, 5'd3, 5'd4, 5'd0, 5'd5, 16'h0);

        // x0 ignores writes and never forwards
        issue(OP_ADDI, 5'd1, 5'd0, 5'd0, 5'd0, 16'h0055);
        issue(OP_ADD, 5'd0, 5'd0, 5'd0, 5'd6, 16'h0);
        issue(OP_ADDI, 5'd0, 5'd0, 5'd0, 5'd7, 16'd1);
        issue(OP_XOR, 5'd0, 5'd1, 5'd0, 5'd8, 16'h0);
        idle(2);

        // fp ops with dependences on all three sources
        issue(OP_ADDI, 5'd0, 5'd0, 5'd0, 5'd9, 16'h8001);
        issue(OP_FMV_W_X, 5'd9, 5'd0, 5'd0, 5'd1, 16'h0);
        issue(OP_FMV_W_X, 5'd2, 5'd0, 5'd0, 5'd2, 16'h0);
        issue(OP_FMV_W_X, 5'd5, 5'd0, 5'd0, 5'd3, 16'h0);
        issue(OP_FSEL3, 5'd1, 5'd2, 5'd3, 5'd4, 16'h0);
        issue(OP_FSGNJ, 5'd3, 5'd4, 5'd0, 5'd5, 16'h0);
        issue(OP_FSGNJX, 5'd4, 5'd1, 5'd0, 5'd6, 16'h0);
        issue(OP_FSEL3, 5'd5, 5'd6, 5'd4, 5'd7, 16'h0);
        issue(OP_FSEL3, 5'd1, 5'd2, 5'd6, 5'd8, 16'h0);   // rs3 at distance 2
        idle(3);

        // same index in the other file must not forward
        issue(OP_ADDI, 5'd0, 5'd0, 5'd0, 5'd10, 16'h0777);
        issue(OP_FMV_X_W, 5'd10, 5'd0, 5'd0, 5'd11, 16'h0);
        issue(OP_FSGNJ, 5'd10, 5'd10, 5'd0, 5'd10, 16'h0);
        issue(OP_ADD, 5'd10, 5'd10, 5'd0, 5'd12, 16'h0);
        issue(OP_FMV_X_W, 5'd10, 5'd0, 5'd0, 5'd13, 16'h0);
        issue(OP_FMV_W_X, 5'd13, 5'd0, 5'd0, 5'd13, 16'h0);
        issue(OP_FSEL3, 5'd13, 5'd13, 5'd13, 5'd14, 16'h0);
        idle(3);

        // long random mix, then a gap-free burst
        random_run(1500, 30);
        random_run(300, 0);

        while (exp_data_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_data_q.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("results are missing: %0d instructions never completed",
                     exp_data_q.size());
            abort_run();
        end
    end

endmodule
